// ==== hdl/miniPipe_cfg.svh ====
`ifndef MINIPIPE_CFG_SVH
`define MINIPIPE_CFG_SVH

// datapath width
`define MP_DATA_W      32

// instruction word width, fixed encoding
`define MP_INST_W      32

// immediate field width, also the LUI shift amount
`define MP_IMM_W       16

// register file geometry
`define MP_REG_ADDR_W  5
`define MP_REG_NUM     32

// index of the hard-wired zero register
`define MP_ZERO_REG    0

`endif

// ==== hdl/miniPipe_pkg.sv ====
package miniPipe_pkg;

    // major opcode in inst[31:26]
    typedef enum logic [5:0] {
        OP_NOP   = 6'h00,  // also what undefined codes decode to
        OP_ADDU  = 6'h01,
        OP_SUBU  = 6'h02,
        OP_AND   = 6'h03,
        OP_OR    = 6'h04,
        OP_XOR   = 6'h05,
        OP_ADDIU = 6'h09,  // sign-extended imm
        OP_ORI   = 6'h0D,  // zero-extended imm
        OP_LUI   = 6'h0F   // imm << 16, no source reg
    } opcode_e;

    // field boundaries inside the instruction word
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 26;
    localparam int RS_MSB  = 25;  // first source
    localparam int RS_LSB  = 21;
    localparam int RT_MSB  = 20;  // second source or imm-form dest
    localparam int RT_LSB  = 16;
    localparam int RD_MSB  = 15;  // reg-form dest
    localparam int RD_LSB  = 11;
    localparam int IMM_MSB = 15;
    localparam int IMM_LSB = 0;

endpackage

// ==== hdl/miniPipe_if.sv ====
`timescale 1ns/1ns
`include "miniPipe_cfg.svh"

// decode <-> register file read ports
interface regRead_if;
    logic [`MP_REG_ADDR_W-1:0] raddr1;
    logic                      re1;
    logic [`MP_REG_ADDR_W-1:0] raddr2;
    logic                      re2;
    logic [`MP_DATA_W-1:0]     rdata1;  // same-cycle read data
    logic [`MP_DATA_W-1:0]     rdata2;

    modport dec (output raddr1, re1, raddr2, re2, input rdata1, rdata2);
    modport rf (input raddr1, re1, raddr2, re2, output rdata1, rdata2);
endinterface

// pending writes of the later stages, newest first
interface fwdBus_if;
    logic                      exWreg,  memWreg,  wbWreg;
    logic [`MP_REG_ADDR_W-1:0] exWaddr, memWaddr, wbWaddr;
    logic [`MP_DATA_W-1:0]     exWdata, memWdata, wbWdata;

    // src is shared, EX stage drives ex*, retire stage drives mem* and wb*
    modport src (output exWreg, exWaddr, exWdata, memWreg, memWaddr, memWdata,
                 wbWreg, wbWaddr, wbWdata);
    modport rf (input exWreg, exWaddr, exWdata, memWreg, memWaddr, memWdata,
                wbWreg, wbWaddr, wbWdata);
endinterface

// ==== hdl/regFile.sv ====
`timescale 1ns/1ns
`include "miniPipe_cfg.svh"

module regFile (
    input  logic       clk,
    input  logic       arstN_i,
    regRead_if.rf      rdPort_i,  // two read ports from decode
    fwdBus_if.rf       fwd_i      // EX/MEM/WB write triplets
);

    logic [`MP_DATA_W-1:0] regs [0:`MP_REG_NUM-1];

    // one read port, the zero rule first and then newest producer wins
    function automatic logic [`MP_DATA_W-1:0] readPort(
        input logic [`MP_REG_ADDR_W-1:0] addr,
        input logic                      en
    );
        logic [`MP_DATA_W-1:0] val;
        if (!en || addr == `MP_ZERO_REG) begin
            val = '0;  // $0 always reads zero, even if someone "wrote" it
        end else if (fwd_i.exWreg && fwd_i.exWaddr == addr) begin
            val = fwd_i.exWdata;  // distance 1, ALU output this cycle
        end else if (fwd_i.memWreg && fwd_i.memWaddr == addr) begin
            val = fwd_i.memWdata;  // distance 2
        end else if (fwd_i.wbWreg && fwd_i.wbWaddr == addr) begin
            // distance 3, write lands at this same edge so bypass the array
            val = fwd_i.wbWdata;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    // write port, driven by the WB triplet
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < `MP_REG_NUM; i++) begin
                regs[i] <= '0;  // array starts out zero
            end
        end else if (fwd_i.wbWreg && fwd_i.wbWaddr != `MP_ZERO_REG) begin
            regs[fwd_i.wbWaddr] <= fwd_i.wbWdata;
        end
    end

    // read ports are purely combinational
    // always_comb also picks up regs and fwd_i read inside the function
    always_comb begin
        rdPort_i.rdata1 = readPort(rdPort_i.raddr1, rdPort_i.re1);
    end

    always_comb begin
        rdPort_i.rdata2 = readPort(rdPort_i.raddr2, rdPort_i.re2);
    end

endmodule

// ==== hdl/instDecode.sv ====
`timescale 1ns/1ns
`include "miniPipe_cfg.svh"

module instDecode (
    input  logic                      clk,
    input  logic                      arstN_i,
    input  logic [`MP_INST_W-1:0]     inst_i,
    input  logic                      instValid_i,
    fwdBus_if.rf                      fwd_i,       // only handed down to regFile
    output logic [`MP_DATA_W-1:0]     operandA_o,
    output logic [`MP_DATA_W-1:0]     operandB_o,
    output miniPipe_pkg::opcode_e     opcode_o,
    output logic [`MP_REG_ADDR_W-1:0] destAddr_o,
    output logic                      destWreg_o
);
    import miniPipe_pkg::*;

    localparam int EXT_W = `MP_DATA_W - `MP_IMM_W;

    regRead_if rdPort ();

    opcode_e                   opc;
    logic [`MP_IMM_W-1:0]      imm;
    logic                      regForm;   // rd <- rs op rt
    logic                      immForm;   // rt <- rs op imm
    logic [`MP_DATA_W-1:0]     immExt;
    logic [`MP_REG_ADDR_W-1:0] dest;
    logic                      wreg;

    // map the raw field, anything unknown becomes a bubble
    always_comb begin
        case (inst_i[OPC_MSB:OPC_LSB])
            OP_ADDU:  opc = OP_ADDU;
            OP_SUBU:  opc = OP_SUBU;
            OP_AND:   opc = OP_AND;
            OP_OR:    opc = OP_OR;
            OP_XOR:   opc = OP_XOR;
            OP_ORI:   opc = OP_ORI;
            OP_ADDIU: opc = OP_ADDIU;
            OP_LUI:   opc = OP_LUI;
            default:  opc = OP_NOP;
        endcase
    end

    assign imm     = inst_i[IMM_MSB:IMM_LSB];
    assign regForm = (opc inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR});
    assign immForm = (opc inside {OP_ORI, OP_ADDIU, OP_LUI});

    // read port setup, LUI has no source at all
    assign rdPort.raddr1 = inst_i[RS_MSB:RS_LSB];
    assign rdPort.re1    = instValid_i && (regForm || (immForm && opc != OP_LUI));
    assign rdPort.raddr2 = inst_i[RT_MSB:RT_LSB];
    assign rdPort.re2    = instValid_i && regForm;

    regFile uRegFile (
        .clk      (clk),
        .arstN_i  (arstN_i),
        .rdPort_i (rdPort),
        .fwd_i    (fwd_i)
    );

    // immediate extension per opcode
    always_comb begin
        case (opc)
            OP_ORI:   immExt = {{EXT_W{1'b0}}, imm};
            OP_ADDIU: immExt = {{EXT_W{imm[`MP_IMM_W-1]}}, imm};  // sign bit copied up
            OP_LUI:   immExt = {{EXT_W{1'b0}}, imm} << `MP_IMM_W;
            default:  immExt = '0;
        endcase
    end

    assign dest = regForm ? inst_i[RD_MSB:RD_LSB] : inst_i[RT_MSB:RT_LSB];
    // nothing to write for bubbles, NOPs or $0
    assign wreg = instValid_i && (opc != OP_NOP) && (dest != `MP_ZERO_REG);

    // ID/EX, control part
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            destWreg_o <= 1'b0;
        end else begin
            destWreg_o <= wreg;
        end
    end

    // ID/EX, payload part
    always_ff @(posedge clk) begin
        operandA_o <= rdPort.rdata1;  // already zero when re1 is low
        operandB_o <= immForm ? immExt : rdPort.rdata2;
        opcode_o   <= opc;
        destAddr_o <= dest;
    end

endmodule

// ==== hdl/execUnit.sv ====
`timescale 1ns/1ns
`include "miniPipe_cfg.svh"

module execUnit (
    input  logic                      clk,
    input  logic                      arstN_i,
    input  logic [`MP_DATA_W-1:0]     operandA_i,
    input  logic [`MP_DATA_W-1:0]     operandB_i,
    input  miniPipe_pkg::opcode_e     opcode_i,
    input  logic [`MP_REG_ADDR_W-1:0] destAddr_i,
    input  logic                      destWreg_i,
    fwdBus_if.src                     fwd_o,       // EX triplet only
    output logic [`MP_REG_ADDR_W-1:0] resAddr_o,
    output logic [`MP_DATA_W-1:0]     resData_o,
    output logic                      resWreg_o
);
    import miniPipe_pkg::*;

    logic [`MP_DATA_W-1:0] aluRes;

    // single-cycle ALU, imm forms reuse the reg-form ops
    always_comb begin
        case (opcode_i)
            OP_ADDU, OP_ADDIU: aluRes = operandA_i + operandB_i;  // no overflow trap
            OP_SUBU:           aluRes = operandA_i - operandB_i;
            OP_AND:            aluRes = operandA_i & operandB_i;
            OP_OR, OP_ORI:     aluRes = operandA_i | operandB_i;
            OP_XOR:            aluRes = operandA_i ^ operandB_i;
            OP_LUI:            aluRes = operandB_i;  // shifted in decode
            default:           aluRes = '0;
        endcase
    end

    // distance-1 forwarding straight from the ALU
    assign fwd_o.exWreg  = destWreg_i;
    assign fwd_o.exWaddr = destAddr_i;
    assign fwd_o.exWdata = aluRes;

    // EX/MEM, enable gets reset
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            resWreg_o <= 1'b0;
        end else begin
            resWreg_o <= destWreg_i;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        resAddr_o <= destAddr_i;
        resData_o <= aluRes;
    end

endmodule

// ==== hdl/retireStage.sv ====
`timescale 1ns/1ns
`include "miniPipe_cfg.svh"

module retireStage (
    input  logic                      clk,
    input  logic                      arstN_i,
    input  logic [`MP_REG_ADDR_W-1:0] resAddr_i,   // EX/MEM contents
    input  logic [`MP_DATA_W-1:0]     resData_i,
    input  logic                      resWreg_i,
    fwdBus_if.src                     fwd_o,       // MEM and WB triplets
    output logic                      wbValid_o,
    output logic [`MP_REG_ADDR_W-1:0] wbAddr_o,
    output logic [`MP_DATA_W-1:0]     wbData_o
);

    // MEM stage only carries the result
    assign fwd_o.memWreg  = resWreg_i;
    assign fwd_o.memWaddr = resAddr_i;
    assign fwd_o.memWdata = resData_i;

    // MEM/WB valid bit
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            wbValid_o <= 1'b0;
        end else begin
            wbValid_o <= resWreg_i;
        end
    end

    always_ff @(posedge clk) begin
        wbAddr_o <= resAddr_i;
        wbData_o <= resData_i;
    end

    // the same register feeds the array write and the outputs
    assign fwd_o.wbWreg  = wbValid_o;
    assign fwd_o.wbWaddr = wbAddr_o;
    assign fwd_o.wbWdata = wbData_o;

endmodule

// ==== hdl/miniPipe.sv ====
`timescale 1ns/1ns
`include "miniPipe_cfg.svh"

module miniPipe (
    input  logic                      clk,
    input  logic                      arstN_i,
    input  logic [`MP_INST_W-1:0]     inst_i,
    input  logic                      instValid_i,  // one instruction per strobe
    output logic                      wbValid_o,
    output logic [`MP_REG_ADDR_W-1:0] wbAddr_o,
    output logic [`MP_DATA_W-1:0]     wbData_o
);
    import miniPipe_pkg::*;

    fwdBus_if fwdBus ();

    // ID/EX
    logic [`MP_DATA_W-1:0]     operandA, operandB;
    opcode_e                   opcode;
    logic [`MP_REG_ADDR_W-1:0] destAddr;
    logic                      destWreg;

    // EX/MEM
    logic [`MP_REG_ADDR_W-1:0] resAddr;
    logic [`MP_DATA_W-1:0]     resData;
    logic                      resWreg;

    instDecode uDecode (
        .clk         (clk),
        .arstN_i     (arstN_i),
        .inst_i      (inst_i),
        .instValid_i (instValid_i),
        .fwd_i       (fwdBus),
        .operandA_o  (operandA),
        .operandB_o  (operandB),
        .opcode_o    (opcode),
        .destAddr_o  (destAddr),
        .destWreg_o  (destWreg)
    );

    execUnit uExec (
        .clk        (clk),
        .arstN_i    (arstN_i),
        .operandA_i (operandA),
        .operandB_i (operandB),
        .opcode_i   (opcode),
        .destAddr_i (destAddr),
        .destWreg_i (destWreg),
        .fwd_o      (fwdBus),
        .resAddr_o  (resAddr),
        .resData_o  (resData),
        .resWreg_o  (resWreg)
    );

    retireStage uRetire (
        .clk       (clk),
        .arstN_i   (arstN_i),
        .resAddr_i (resAddr),
        .resData_i (resData),
        .resWreg_i (resWreg),
        .fwd_o     (fwdBus),
        .wbValid_o (wbValid_o),
        .wbAddr_o  (wbAddr_o),
        .wbData_o  (wbData_o)
    );

endmodule

// ==== sim/miniPipe_checker.sv ====
`timescale 1ns/1ns
`include "miniPipe_cfg.svh"

module miniPipe_checker (
    input logic                      clk,
    input logic                      arstN_i,
    input logic [`MP_INST_W-1:0]     inst_i,
    input logic                      instValid_i,
    input logic                      wbValid_i,
    input logic [`MP_REG_ADDR_W-1:0] wbAddr_i
);
    import miniPipe_pkg::*;

    int unsigned               failCount = 0;  // read by the testbench at the end
    logic [OPC_MSB-OPC_LSB:0]  opc;
    logic                      regForm;
    logic                      immForm;
    logic [`MP_REG_ADDR_W-1:0] dest;
    logic                      retires;      // instruction that must show up at wb

    assign opc     = inst_i[OPC_MSB:OPC_LSB];
    assign regForm = opc inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR};
    assign immForm = opc inside {OP_ORI, OP_ADDIU, OP_LUI};
    assign dest    = regForm ? inst_i[RD_MSB:RD_LSB] : inst_i[RT_MSB:RT_LSB];
    assign retires = instValid_i && (regForm || immForm) && (dest != '0);

    quietInReset: assert property (@(posedge clk) !arstN_i |-> !wbValid_i)
        else begin
            failCount++;
            $error("wbValid_o high while reset is asserted");
        end

    // $0 is never a writeback target
    noZeroWrite: assert property (@(posedge clk) disable iff (!arstN_i)
        wbValid_i |-> wbAddr_i != '0)
        else begin
            failCount++;
            $error("writeback to register 0");
        end

    // outputs change after edge k+2, seen at the edge after that
    fixedLatency: assert property (@(posedge clk) disable iff (!arstN_i)
        retires |-> ##3 wbValid_i)
        else begin
            failCount++;
            $error("instruction did not reach writeback on time");
        end

endmodule

bind miniPipe miniPipe_checker uChecker (
    .clk         (clk),
    .arstN_i     (arstN_i),
    .inst_i      (inst_i),
    .instValid_i (instValid_i),
    .wbValid_i   (wbValid_o),
    .wbAddr_i    (wbAddr_o)
);

// ==== sim/miniPipe_tb.sv ====
`timescale 1ns/1ns
`include "miniPipe_cfg.svh"

module miniPipe_tb;

    localparam int REC_W       = 5;   // id, inst, expect, addr, data
    localparam int MAX_REC     = 64;
    localparam int GOLD_WORDS  = REC_W * MAX_REC;
    localparam int BUBBLE_TEST = 5;   // replayed with random gaps
    localparam int DRAIN_LIMIT = 40;  // cycles well past the pipe depth
    localparam int WB_LATENCY  = 2;   // edges from sampling to wb outputs

    logic                      clk;
    logic                      arstN;
    logic [`MP_INST_W-1:0]     inst;
    logic                      instValid;
    logic                      wbValid;
    logic [`MP_REG_ADDR_W-1:0] wbAddr;
    logic [`MP_DATA_W-1:0]     wbData;

    logic [31:0] gold [0:GOLD_WORDS-1];
    logic [31:0] expAddr [$];  // pending writebacks in issue order
    logic [31:0] expData [$];
    int          expEdge [$];  // edge that sampled the instruction

    int   edgeCount = 0;
    int   checks    = 0;
    int   errors    = 0;
    logic timedOut  = 1'b0;

    miniPipe DUT (
        .clk         (clk),
        .arstN_i     (arstN),
        .inst_i      (inst),
        .instValid_i (instValid),
        .wbValid_o   (wbValid),
        .wbAddr_o    (wbAddr),
        .wbData_o    (wbData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        edgeCount <= edgeCount + 1;
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // outputs settle after the rising edge and are read half a cycle later
    always @(negedge clk) begin
        if (wbValid !== 1'b0) begin
            if (!arstN) begin
                errors++;
                $display("wbValid_o went high at %0t while reset was held", $time);
            end else if (expAddr.size() == 0) begin
                errors++;
                $display("unexpected writeback to r%0d at %0t, nothing pending", wbAddr, $time);
            end else begin
                compare("wbAddr_o", 32'(wbAddr), expAddr.pop_front());
                compare("wbData_o", wbData, expData.pop_front());
                compare("wb latency", 32'(edgeCount - expEdge.pop_front()), WB_LATENCY);
            end
        end
    end

    task automatic issue(input logic [31:0] word, input logic [31:0] wants,
                         input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        inst      = word;
        instValid = 1'b1;
        if (wants != 0) begin
            expAddr.push_back(addr);
            expData.push_back(data);
            expEdge.push_back(edgeCount + 1);  // sampled at the coming rising edge
        end
    endtask

    // bubbles carry junk words that the pipe has to ignore
    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            inst      = $urandom();
            instValid = 1'b0;
        end
    endtask

    task automatic drainResults();
        int waited;
        waited = 0;
        idle(1);
        while (expAddr.size() != 0 && waited < DRAIN_LIMIT) begin
            idle(1);
            waited++;
        end
        if (expAddr.size() != 0) begin
            timedOut = 1'b1;
            $display("timeout: %0d writebacks still missing after %0d cycles",
                     expAddr.size(), DRAIN_LIMIT);
        end
    endtask

    initial begin
        int rec;
        int curTest;
        int errStart;
        int chkStart;
        int nTests;
        void'($urandom(8608));
        arstN     = 1'b0;
        inst      = '0;
        instValid = 1'b0;
        rec       = 0;
        nTests    = 0;
        for (int i = 0; i < GOLD_WORDS; i++) begin
            gold[i] = 32'hFFFF0000 | 32'(i);  // above any test id so it marks the end
        end
        $readmemh("sim/miniPipe_golden.txt", gold);

        // nothing may retire in reset or in the idle cycles after it
        errStart = errors;
        repeat (16) @(negedge clk);
        arstN = 1'b1;
        idle(4);
        $display("test reset/idle: %0d errors", errors - errStart);
        nTests++;

        while (rec < MAX_REC && gold[rec * REC_W] < 32'h100 && !timedOut) begin
            curTest  = int'(gold[rec * REC_W]);
            errStart = errors;
            chkStart = checks;
            while (rec < MAX_REC && gold[rec * REC_W] == 32'(curTest)) begin
                if (curTest == BUBBLE_TEST) begin
                    idle($urandom_range(3, 0));
                end
                issue(gold[rec * REC_W + 1], gold[rec * REC_W + 2],
                      gold[rec * REC_W + 3], gold[rec * REC_W + 4]);
                rec++;
            end
            drainResults();
            $display("test %0d: %0d checks, %0d errors", curTest, checks - chkStart,
                     errors - errStart);
            nTests++;
        end

        if (DUT.uChecker.failCount != 0) begin
            $display("bound checker saw %0d assertion failures", DUT.uChecker.failCount);
        end
        errors = errors + int'(DUT.uChecker.failCount);
        $display("%0d tests, %0d checks, %0d errors", nTests, checks, errors);
        if (errors == 0 && !timedOut) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sim/miniPipe_golden.txt ====
// test  inst  expect  waddr  wdata   (all hex, one instruction per line)
// expect 0 means no writeback, waddr and wdata unused then
01 34018001 1 01 00008001
01 2402FFFC 1 02 FFFFFFFC
01 3C031234 1 03 12340000
01 24440010 1 04 0000000C
01 34655678 1 05 12345678
02 04A13000 1 06 1234D679
02 08A43800 1 07 1234566C
02 0CA44000 1 08 00000008
02 10614800 1 09 12348001
02 14A25000 1 0A EDCBA984
03 340B0001 1 0B 00000001
03 340B0002 1 0B 00000002
03 340B0003 1 0B 00000003
03 05606000 1 0C 00000003
03 3C0DABCD 1 0D ABCD0000
03 05AD7000 1 0E 579A0000
03 15AC7800 1 0F ABCD0003
03 09AE8000 1 10 54330000
03 11F08800 1 11 FFFF0003
04 34001234 0 00 00000000
04 04009000 1 12 00000000
04 24A00007 0 00 00000000
04 10019800 1 13 00008001
04 FC210000 0 00 00000000
04 0420A000 1 14 00008001
05 340B0001 1 0B 00000001
05 340B0002 1 0B 00000002
05 340B0003 1 0B 00000003
05 05606000 1 0C 00000003
05 3C0DABCD 1 0D ABCD0000
05 05AD7000 1 0E 579A0000
05 09AE8000 1 10 54330000

// ==== miniPipe.f ====
+incdir+hdl
hdl/miniPipe_pkg.sv
hdl/miniPipe_if.sv
hdl/regFile.sv
hdl/instDecode.sv
hdl/execUnit.sv
hdl/retireStage.sv
hdl/miniPipe.sv
sim/miniPipe_checker.sv
sim/miniPipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build from the file list, run, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module miniPipe_tb -f miniPipe.f -o miniPipe_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/miniPipe_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0
